// ==== design/delay_line.sv ====
`timescale 1ns/1ps
`default_nettype none

module delay_line #(
  parameter int DEPTH = 1,
  parameter type payload_t = logic
) (
  input wire clk,
  input wire payload_t in_data,
  output payload_t out_data
);

  payload_t stage [DEPTH];

  always_ff @(posedge clk) begin
    stage[0] <= in_data;
    for (int i = 1; i < DEPTH; i++) begin
      stage[i] <= stage[i-1];  // shift one stage per cycle
    end
  end

  assign out_data = stage[DEPTH-1];

endmodule

`default_nettype wire

// ==== design/link_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module link_ram #(
  parameter int NUM_PUSH = 2,
  parameter int SRAM_DELAY = 2
) (
  input wire clk,
  input wire [NUM_PUSH-1:0] wr_en,
  input wire mq_pkg::link_addr_t wr_addr [NUM_PUSH],
  input wire mq_pkg::link_addr_t wr_data [NUM_PUSH],
  input wire mq_pkg::link_addr_t rd_addr,
  output mq_pkg::link_addr_t rd_data
);

  // next pointer per link address
  mq_pkg::link_addr_t mem [mq_pkg::NUM_ADDR];

  mq_pkg::link_addr_t rd_word;

  always_ff @(posedge clk) begin
    for (int p = 0; p < NUM_PUSH; p++) begin
      if (wr_en[p]) begin
        mem[wr_addr[p]] <= wr_data[p];  // later port overrides earlier
      end
    end
  end

  assign rd_word = mem[rd_addr];

  // models the sram read pipeline
  delay_line #(
    .DEPTH     (SRAM_DELAY),
    .payload_t (mq_pkg::link_addr_t)
  ) u_rd_pipe (
    .clk      (clk),
    .in_data  (rd_word),
    .out_data (rd_data)
  );

endmodule

`default_nettype wire

// ==== design/mq_pkg.sv ====
`default_nettype none

package mq_pkg;

  parameter int QUEUE_BITS = 3;
  parameter int NUM_QUEUES = 1 << QUEUE_BITS;

  parameter int ADDR_BITS = 6;
  parameter int NUM_ADDR = 1 << ADDR_BITS;    // link memory words

  typedef logic [QUEUE_BITS-1:0] queue_id_t;

  // push payload and pop result
  typedef logic [ADDR_BITS-1:0] link_addr_t;

  // one extra bit so a queue can hold every address
  typedef logic [ADDR_BITS:0] count_t;

  typedef struct packed {
    queue_id_t queue;
    logic      refill;
  } refill_t;

endpackage

`default_nettype wire

// ==== design/multi_queue_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module multi_queue_top #(
  parameter int NUM_PUSH = 2,
  parameter int SRAM_DELAY = 2
) (
  input wire clk,
  input wire rst,

  input wire [NUM_PUSH-1:0] push,
  input wire mq_pkg::queue_id_t push_queue [NUM_PUSH],
  input wire mq_pkg::link_addr_t push_addr [NUM_PUSH],

  input wire pop,
  input wire mq_pkg::queue_id_t pop_queue,
  output logic pop_vld,
  output mq_pkg::link_addr_t pop_addr,

  output logic ready
);

  logic [NUM_PUSH-1:0] push_gated;
  logic pop_gated;

  logic [NUM_PUSH-1:0] link_wr_en;
  mq_pkg::link_addr_t link_wr_addr [NUM_PUSH];
  mq_pkg::link_addr_t link_wr_data [NUM_PUSH];
  mq_pkg::link_addr_t link_rd_addr;
  mq_pkg::link_addr_t link_rd_data;

  always_ff @(posedge clk) begin
    ready <= !rst;  // one cycle after reset release
  end

  assign push_gated = push & {NUM_PUSH{ready}};
  assign pop_gated = pop & ready;

  queue_state_table #(
    .NUM_PUSH   (NUM_PUSH),
    .SRAM_DELAY (SRAM_DELAY)
  ) u_qst (
    .clk          (clk),
    .rst          (rst),
    .push         (push_gated),
    .push_queue   (push_queue),
    .push_addr    (push_addr),
    .pop          (pop_gated),
    .pop_queue    (pop_queue),
    .pop_vld      (pop_vld),
    .pop_addr     (pop_addr),
    .link_wr_en   (link_wr_en),
    .link_wr_addr (link_wr_addr),
    .link_wr_data (link_wr_data),
    .link_rd_addr (link_rd_addr),
    .link_rd_data (link_rd_data)
  );

  link_ram #(
    .NUM_PUSH   (NUM_PUSH),
    .SRAM_DELAY (SRAM_DELAY)
  ) u_link_ram (
    .clk     (clk),
    .wr_en   (link_wr_en),
    .wr_addr (link_wr_addr),
    .wr_data (link_wr_data),
    .rd_addr (link_rd_addr),
    .rd_data (link_rd_data)
  );

endmodule

`default_nettype wire

// ==== design/queue_state_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module queue_state_table #(
  parameter int NUM_PUSH = 2,
  parameter int SRAM_DELAY = 2
) (
  input wire clk,
  input wire rst,

  input wire [NUM_PUSH-1:0] push,
  input wire mq_pkg::queue_id_t push_queue [NUM_PUSH],
  input wire mq_pkg::link_addr_t push_addr [NUM_PUSH],

  input wire pop,
  input wire mq_pkg::queue_id_t pop_queue,
  output logic pop_vld,
  output mq_pkg::link_addr_t pop_addr,

  output logic [NUM_PUSH-1:0] link_wr_en,
  output mq_pkg::link_addr_t link_wr_addr [NUM_PUSH],
  output mq_pkg::link_addr_t link_wr_data [NUM_PUSH],
  output mq_pkg::link_addr_t link_rd_addr,
  input wire mq_pkg::link_addr_t link_rd_data
);

  mq_pkg::link_addr_t head [mq_pkg::NUM_QUEUES];
  mq_pkg::link_addr_t tail [mq_pkg::NUM_QUEUES];
  mq_pkg::count_t count [mq_pkg::NUM_QUEUES];

  mq_pkg::link_addr_t head_next [mq_pkg::NUM_QUEUES];
  mq_pkg::link_addr_t tail_next [mq_pkg::NUM_QUEUES];
  mq_pkg::count_t count_next [mq_pkg::NUM_QUEUES];

  logic pop_last;    // pop takes the only entry
  logic pop_refill;  // pop leaves entries behind, head must be refetched

  logic [NUM_PUSH-1:0] first_push;
  logic [NUM_PUSH-1:0] head_load;

  mq_pkg::refill_t refill_in;
  mq_pkg::refill_t refill_out;

  assign pop_last = pop && (count[pop_queue] == 1);
  assign pop_refill = pop && (count[pop_queue] > 1);

  assign pop_vld = pop;
  assign pop_addr = head[pop_queue];

  // next pointer of the old head
  assign link_rd_addr = head[pop_queue];

  // lowest port per target queue is the one that may load the head
  always_comb begin
    for (int p = 0; p < NUM_PUSH; p++) begin
      first_push[p] = push[p];
      for (int q = 0; q < p; q++) begin
        if (push[q] && (push_queue[q] == push_queue[p])) begin
          first_push[p] = 1'b0;
        end
      end
      head_load[p] = first_push[p] &&
                     ((count[push_queue[p]] == 0) ||
                      (pop_last && (pop_queue == push_queue[p])));
    end
  end

  // link write address per port, chained behind lower ports to the same queue
  always_comb begin
    for (int p = 0; p < NUM_PUSH; p++) begin
      if (count[push_queue[p]] != 0) begin
        link_wr_addr[p] = tail[push_queue[p]];
      end else begin
        link_wr_addr[p] = push_addr[p];  // empty queue, word is don't care
      end
      for (int q = 0; q < p; q++) begin
        if (push[q] && (push_queue[q] == push_queue[p])) begin
          link_wr_addr[p] = push_addr[q];
        end
      end
      link_wr_data[p] = push_addr[p];
    end
  end

  assign link_wr_en = push;

  always_comb begin
    head_next = head;
    tail_next = tail;
    count_next = count;

    if (refill_out.refill) begin
      head_next[refill_out.queue] = link_rd_data;
    end

    if (pop) begin
      count_next[pop_queue] = count_next[pop_queue] - 1'b1;
    end

    for (int p = 0; p < NUM_PUSH; p++) begin
      if (head_load[p]) begin
        head_next[push_queue[p]] = push_addr[p];
      end
      if (push[p]) begin
        tail_next[push_queue[p]] = push_addr[p];  // highest port ends up as tail
        count_next[push_queue[p]] = count_next[push_queue[p]] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    head <= head_next;
    tail <= tail_next;
    if (rst) begin
      count <= '{default: '0};
    end else begin
      count <= count_next;
    end
  end

  // which queue gets link_rd_data when it comes back
  assign refill_in.queue = pop_queue;
  assign refill_in.refill = pop_refill && !rst;  // flushes the line during reset

  delay_line #(
    .DEPTH     (SRAM_DELAY),
    .payload_t (mq_pkg::refill_t)
  ) u_refill_pipe (
    .clk      (clk),
    .in_data  (refill_in),
    .out_data (refill_out)
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module multi_queue_tb -o sim_multi_queue

out=$(./obj_dir/sim_multi_queue) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

// ==== test/multi_queue_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module multi_queue_props #(
  parameter int SRAM_DELAY = 2
) (
  input wire clk,
  input wire rst,
  input wire pop,
  input wire mq_pkg::queue_id_t pop_queue,
  input wire pop_vld,
  input wire pop_refill,
  input wire mq_pkg::count_t count [mq_pkg::NUM_QUEUES]
);

  logic [SRAM_DELAY-1:0] recent_vld;              // refilling pops still in flight
  mq_pkg::queue_id_t recent_queue [SRAM_DELAY];
  mq_pkg::count_t pop_count;
  logic repeat_hit;

  assign pop_count = count[pop_queue];

  always_comb begin
    repeat_hit = 1'b0;
    for (int i = 0; i < SRAM_DELAY; i++) begin
      if (recent_vld[i] && (recent_queue[i] == pop_queue)) begin
        repeat_hit = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      recent_vld <= '0;
    end else begin
      recent_vld[0] <= pop_refill;
      for (int i = 1; i < SRAM_DELAY; i++) begin
        recent_vld[i] <= recent_vld[i-1];
      end
    end
    recent_queue[0] <= pop_queue;
    for (int i = 1; i < SRAM_DELAY; i++) begin
      recent_queue[i] <= recent_queue[i-1];
    end
  end

  pop_not_empty: assert property (@(posedge clk) disable iff (rst)
    pop |-> (pop_count != '0))
    else $error("pop of empty queue %0d", pop_queue);

  pop_not_early: assert property (@(posedge clk) disable iff (rst)
    pop |-> !repeat_hit)
    else $error("queue %0d popped again while its head refill is pending", pop_queue);

  no_pop_in_reset: assert property (@(posedge clk)
    rst |-> !pop_vld)
    else $error("pop_vld high during reset");

endmodule

bind queue_state_table multi_queue_props #(
  .SRAM_DELAY (SRAM_DELAY)
) u_props (
  .clk        (clk),
  .rst        (rst),
  .pop        (pop),
  .pop_queue  (pop_queue),
  .pop_vld    (pop_vld),
  .pop_refill (pop_refill),
  .count      (count)
);

`default_nettype wire

// ==== test/multi_queue_stimulus.txt ====
// columns (hex): push0 queue0 addr0 push1 queue1 addr1 pop pop_queue ready pop_vld pop_addr
// one line per cycle from the first cycle after reset; pop_addr is compared only when pop_vld is 1
1 7 3e 0 0 00 1 0 0 0 00
0 0 00 0 0 00 0 0 1 0 00
1 1 01 0 0 00 0 0 1 0 00
1 1 02 0 0 00 0 0 1 0 00
1 1 03 0 0 00 0 0 1 0 00
1 1 04 0 0 00 0 0 1 0 00
1 1 05 0 0 00 0 0 1 0 00
0 0 00 0 0 00 1 1 1 1 01
1 2 10 1 2 11 0 0 1 0 00
1 3 20 0 0 00 0 0 1 0 00
0 0 00 0 0 00 1 1 1 1 02
0 0 00 0 0 00 1 2 1 1 10
1 3 21 0 0 00 1 3 1 1 20
0 0 00 0 0 00 1 1 1 1 03
0 0 00 0 0 00 1 2 1 1 11
0 0 00 0 0 00 1 3 1 1 21
0 0 00 0 0 00 1 1 1 1 04
0 0 00 0 0 00 0 0 1 0 00
0 0 00 0 0 00 0 0 1 0 00
0 0 00 0 0 00 1 1 1 1 05
1 4 30 1 5 38 0 0 1 0 00
1 4 31 1 5 39 0 0 1 0 00
1 4 32 1 5 3a 0 0 1 0 00
1 4 33 1 4 34 0 0 1 0 00
0 0 00 0 0 00 1 4 1 1 30
0 0 00 0 0 00 1 5 1 1 38
0 0 00 0 0 00 0 0 1 0 00
0 0 00 0 0 00 1 4 1 1 31
0 0 00 0 0 00 1 5 1 1 39
1 5 3b 0 0 00 0 0 1 0 00
0 0 00 0 0 00 1 4 1 1 32
0 0 00 0 0 00 1 5 1 1 3a
0 0 00 0 0 00 0 0 1 0 00
0 0 00 0 0 00 1 4 1 1 33
0 0 00 0 0 00 1 5 1 1 3b
0 0 00 0 0 00 0 0 1 0 00
0 0 00 0 0 00 1 4 1 1 34
1 6 02 1 7 11 0 0 1 0 00
1 6 01 1 7 10 0 0 1 0 00
1 6 31 1 7 30 0 0 1 0 00
0 0 00 0 0 00 1 6 1 1 02
0 0 00 0 0 00 1 7 1 1 11
0 0 00 0 0 00 0 0 1 0 00
0 0 00 0 0 00 1 6 1 1 01
0 0 00 0 0 00 1 7 1 1 10
0 0 00 0 0 00 0 0 1 0 00
0 0 00 0 0 00 1 6 1 1 31
0 0 00 0 0 00 1 7 1 1 30
1 0 05 0 0 00 0 0 1 0 00
1 0 04 1 0 03 1 0 1 1 05
0 0 00 0 0 00 1 0 1 1 04
0 0 00 0 0 00 0 0 1 0 00
0 0 00 0 0 00 0 0 1 0 00
0 0 00 0 0 00 1 0 1 1 03
0 0 00 0 0 00 0 0 1 0 00

// ==== test/multi_queue_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module multi_queue_tb;

  localparam int NUM_PUSH = 2;
  localparam int SRAM_DELAY = 2;

  localparam int PERIOD = 40;
  localparam int RESET_CYCLES = 16;
  localparam int MARGIN_CYCLES = 20;
  localparam int DRIVE_DELAY = 2;   // after the rising edge
  localparam int SAMPLE_LEAD = 2;   // before the next rising edge
  localparam int MAX_LINES = 256;
  localparam string STIM_FILE = "test/multi_queue_stimulus.txt";

  logic clk;
  logic rst;
  logic [NUM_PUSH-1:0] push;
  mq_pkg::queue_id_t push_queue [NUM_PUSH];
  mq_pkg::link_addr_t push_addr [NUM_PUSH];
  logic pop;
  mq_pkg::queue_id_t pop_queue;
  logic pop_vld;
  mq_pkg::link_addr_t pop_addr;
  logic ready;

  // one entry per stimulus line
  logic [NUM_PUSH-1:0] line_push [MAX_LINES];
  mq_pkg::queue_id_t line_push_queue [MAX_LINES][NUM_PUSH];
  mq_pkg::link_addr_t line_push_addr [MAX_LINES][NUM_PUSH];
  logic line_pop [MAX_LINES];
  mq_pkg::queue_id_t line_pop_queue [MAX_LINES];
  logic line_ready [MAX_LINES];
  logic line_vld [MAX_LINES];
  mq_pkg::link_addr_t line_addr [MAX_LINES];
  int line_src [MAX_LINES];   // line number in the file
  int line_count;

  int checks;
  int errors;
  int cycle_count = 0;
  int cycle_limit;

  multi_queue_top #(
    .NUM_PUSH   (NUM_PUSH),
    .SRAM_DELAY (SRAM_DELAY)
  ) dut (
    .clk        (clk),
    .rst        (rst),
    .push       (push),
    .push_queue (push_queue),
    .push_addr  (push_addr),
    .pop        (pop),
    .pop_queue  (pop_queue),
    .pop_vld    (pop_vld),
    .pop_addr   (pop_addr),
    .ready      (ready)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles, the stimulus did not complete", cycle_count);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic clear_inputs();
    push = '0;
    for (int p = 0; p < NUM_PUSH; p++) begin
      push_queue[p] = '0;
      push_addr[p] = '0;
    end
    pop = 1'b0;
    pop_queue = '0;
  endtask

  task automatic load_stimulus();
    int fd;
    int n;
    int src;
    int f_push0;
    int f_queue0;
    int f_addr0;
    int f_push1;
    int f_queue1;
    int f_addr1;
    int f_pop;
    int f_pop_queue;
    int f_ready;
    int f_vld;
    int f_addr;
    logic is_comment;
    string text;
    line_count = 0;
    src = 0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("could not open the stimulus file %s", STIM_FILE);
    end else begin
      while ($fgets(text, fd) != 0) begin
        src++;
        is_comment = (text.len() >= 2) && (text.substr(0, 1) == "//");
        if (!is_comment) begin
          n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h",
                      f_push0, f_queue0, f_addr0, f_push1, f_queue1, f_addr1,
                      f_pop, f_pop_queue, f_ready, f_vld, f_addr);
          if (n == 11 && line_count < MAX_LINES) begin
            line_push[line_count][0] = f_push0[0];
            line_push[line_count][1] = f_push1[0];
            line_push_queue[line_count][0] = mq_pkg::queue_id_t'(f_queue0);
            line_push_queue[line_count][1] = mq_pkg::queue_id_t'(f_queue1);
            line_push_addr[line_count][0] = mq_pkg::link_addr_t'(f_addr0);
            line_push_addr[line_count][1] = mq_pkg::link_addr_t'(f_addr1);
            line_pop[line_count] = f_pop[0];
            line_pop_queue[line_count] = mq_pkg::queue_id_t'(f_pop_queue);
            line_ready[line_count] = f_ready[0];
            line_vld[line_count] = f_vld[0];
            line_addr[line_count] = mq_pkg::link_addr_t'(f_addr);
            line_src[line_count] = src;
            line_count++;
          end else if (n > 0) begin
            $display("stimulus line %0d could not be used", src);
            errors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_line(input int i);
    push = line_push[i];
    for (int p = 0; p < NUM_PUSH; p++) begin
      push_queue[p] = line_push_queue[i][p];
      push_addr[p] = line_push_addr[i][p];
    end
    pop = line_pop[i];
    pop_queue = line_pop_queue[i];
  endtask

  task automatic check_reset_outputs();
    checks++;
    assert (ready === 1'b0) else begin
      $display("FAIL %0t: ready is %b during reset, expected 0", $time, ready);
      errors++;
    end
    checks++;
    assert (pop_vld === 1'b0) else begin
      $display("FAIL %0t: pop_vld is %b during reset, expected 0", $time, pop_vld);
      errors++;
    end
  endtask

  task automatic check_line(input int i);
    checks++;
    assert (ready === line_ready[i]) else begin
      $display("FAIL %0t: line %0d ready is %b, expected %b",
               $time, line_src[i], ready, line_ready[i]);
      errors++;
    end
    checks++;
    assert (pop_vld === line_vld[i]) else begin
      $display("FAIL %0t: line %0d pop_vld is %b, expected %b",
               $time, line_src[i], pop_vld, line_vld[i]);
      errors++;
    end
    if (line_vld[i]) begin
      checks++;
      assert (pop_addr === line_addr[i]) else begin
        $display("FAIL %0t: line %0d pop_addr is %h, expected %h",
                 $time, line_src[i], pop_addr, line_addr[i]);
        errors++;
      end
    end
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      #(DRIVE_DELAY);
      check_reset_outputs();
      pop = 1'b1;  // ignored while ready is low
      pop_queue = mq_pkg::queue_id_t'(i);
    end
    rst = 1'b0;  // first stimulus line follows in this cycle
  endtask

  task automatic run_stimulus();
    for (int i = 0; i < line_count; i++) begin
      drive_line(i);
      #(PERIOD - DRIVE_DELAY - SAMPLE_LEAD);
      check_line(i);
      @(posedge clk);
      #(DRIVE_DELAY);
    end
    clear_inputs();
  endtask

  initial begin
    rst = 1'b1;
    clear_inputs();
    checks = 0;
    errors = 0;
    load_stimulus();
    cycle_limit = line_count + RESET_CYCLES + MARGIN_CYCLES;
    if (line_count == 0) begin
      $display("no stimulus lines found in %s", STIM_FILE);
      errors++;
    end else begin
      apply_reset();
      run_stimulus();
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/mq_pkg.sv
design/delay_line.sv
design/link_ram.sv
design/queue_state_table.sv
design/multi_queue_top.sv
test/multi_queue_props.sv
test/multi_queue_tb.sv
